// ==== nasti_buf_chain.f ====
+incdir+dv
source/nasti_pkg.sv
source/nasti_channel.sv
source/nasti_buf.sv
source/nasti_mem.sv
source/nasti_buf_chain.sv
dv/nasti_buf_chain_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module nasti_buf_chain_tb -f nasti_buf_chain.f
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

out=$(./obj_dir/Vnasti_buf_chain_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Test OK" <<< "$out"; then
   exit 0
fi
exit 1

// ==== dv/nasti_tb_tasks.svh ====
// NASTI channel driver tasks

function automatic logic [31:0] next_rand();
   rand_state = rand_state * 32'd1664525 + 32'd1013904223;   // LCG step
   return rand_state;
endfunction

function automatic nasti_resp_e burst_resp(input int word, input int len);
   return (word + len >= MEM_WORDS) ? SLVERR : OKAY;   // any beat past the end
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
   checks++;
   assert (got === exp) else begin
      $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      errors++;
   end
endtask

task automatic write_burst(input logic [1:0] id, input int word, input int len, input bit rnd_strb);
   int          i;
   int          b;
   logic [31:0] data;
   logic [3:0]  strb;
   @(posedge clk);
   aw_id    <= id;
   aw_addr  <= 12'(word * 4);
   aw_len   <= 8'(len);
   aw_valid <= 1'b1;
   @(negedge clk);
   while (!aw_ready) @(negedge clk);
   @(posedge clk);
   aw_valid <= 1'b0;
   for (i = 0; i <= len; i++) begin
      data = next_rand();
      strb = rnd_strb ? 4'(next_rand()) : 4'hf;
      w_data  <= data;
      w_strb  <= strb;
      w_last  <= (i == len);
      w_valid <= 1'b1;
      if (word + i < MEM_WORDS)
         for (b = 0; b < 4; b++)
            if (strb[b]) model[word+i][b*8 +: 8] = data[b*8 +: 8];
      @(negedge clk);
      while (!w_ready) @(negedge clk);
      @(posedge clk);   // beat taken here
   end
   w_valid <= 1'b0;
   w_last  <= 1'b0;
endtask

task automatic expect_resp(input logic [1:0] id, input nasti_resp_e resp, input bit stall);
   bit done;
   done = 0;
   while (!done) begin
      @(posedge clk);
      b_ready <= stall ? (next_rand() % 3 != 0) : 1'b1;
      @(negedge clk);
      if (b_valid && b_ready) begin
         check_value("b_id", b_id, id);
         check_value("b_resp", b_resp, resp);
         done = 1;
      end
   end
   @(posedge clk);
   b_ready <= 1'b0;
endtask

task automatic send_ar(input logic [1:0] id, input int word, input int len);
   @(posedge clk);
   ar_id    <= id;
   ar_addr  <= 12'(word * 4);
   ar_len   <= 8'(len);
   ar_valid <= 1'b1;
   @(negedge clk);
   while (!ar_ready) @(negedge clk);
   @(posedge clk);
   ar_valid <= 1'b0;
endtask

task automatic collect_read(input logic [1:0] id, input int word, input int len, input bit stall);
   int          beat;
   bit          held;
   logic [31:0] exp;
   beat = 0;
   held = 0;
   while (beat <= len) begin
      @(posedge clk);
      r_ready <= stall ? (next_rand() % 3 != 0) : 1'b1;
      @(negedge clk);
      if (held) begin
         assert (r_valid) else begin
            $display("r_valid dropped at %0t ns before its beat was accepted", $time);
            errors++;
         end
      end
      if (r_valid && r_ready) begin
         exp = (word + beat < MEM_WORDS) ? model[word+beat] : 32'h0;
         check_value("r_id", r_id, id);
         check_value("r_data", r_data, exp);
         check_value("r_resp", r_resp, burst_resp(word, len));
         check_value("r_last", r_last, beat == len);
         beat++;
         held = 0;
      end else begin
         held = r_valid;
      end
   end
   @(posedge clk);
   r_ready <= 1'b0;
endtask

task automatic read_burst(input logic [1:0] id, input int word, input int len, input bit stall);
   send_ar(id, word, len);
   collect_read(id, word, len, stall);
endtask

// ==== dv/nasti_buf_chain_tb.sv ====
// buffered NASTI path testbench
`timescale 1ns/1ns

module nasti_buf_chain_tb;
   import nasti_pkg::*;

   localparam int MEM_WORDS = 256;
   localparam int TIMEOUT   = 4000;   // cycles

   logic              clk, rstn;
   logic [1:0]        aw_id, ar_id, b_id, r_id;
   logic [11:0]       aw_addr, ar_addr;
   logic [7:0]        aw_len, ar_len;
   logic              aw_valid, aw_ready, ar_valid, ar_ready;
   logic [31:0]       w_data, r_data;
   logic [3:0]        w_strb;
   logic              w_last, w_valid, w_ready;
   nasti_pkg::nasti_resp_e b_resp, r_resp;
   logic              b_valid, b_ready;
   logic              r_last, r_valid, r_ready;

   logic [31:0] model [MEM_WORDS];   // reference memory
   logic [31:0] rand_state = 32'h77773c04;
   int          checks = 0;
   int          errors = 0;
   int          test_errors = 0;
   int          cycles = 0;
   int          word, len, n;

   nasti_buf_chain DUT (.*);

   `include "nasti_tb_tasks.svh"

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT) begin
         $display("timeout: run stopped after %0d cycles, memory %s", cycles,
                  (DUT.u_mem.state == nasti_pkg::IDLE) ? "idle" : "busy");
         $display("Test FAILED");
         $finish;
      end
   end

   task automatic end_test(input string name);
      $display("%s: %0d errors", name, errors - test_errors);
      test_errors = errors;
   endtask

   initial begin
      clk = 0;
      rstn = 0;
      {aw_id, aw_addr, aw_len, aw_valid} = '0;
      {w_data, w_strb, w_last, w_valid} = '0;
      {ar_id, ar_addr, ar_len, ar_valid} = '0;
      b_ready = 0;
      r_ready = 0;
      repeat (2) @(posedge clk);
      rstn <= 1'b1;
      @(negedge clk);

      check_value("aw_ready", aw_ready, 1);
      check_value("w_ready", w_ready, 1);
      check_value("ar_ready", ar_ready, 1);
      check_value("b_valid", b_valid, 0);
      check_value("r_valid", r_valid, 0);
      end_test("test 1 reset state");

      write_burst(2'd1, 16, 0, 0);
      expect_resp(2'd1, OKAY, 0);
      read_burst(2'd2, 16, 0, 0);
      end_test("test 2 single write and read");

      write_burst(2'd0, 32, 3, 0);   // fill first, strobes merge on top
      expect_resp(2'd0, OKAY, 0);
      write_burst(2'd3, 32, 3, 1);
      expect_resp(2'd3, OKAY, 0);
      read_burst(2'd1, 32, 3, 0);
      end_test("test 3 burst with strobes");

      write_burst(2'd1, 0, 1, 0);   // words the overflow would wrap onto
      expect_resp(2'd1, OKAY, 0);
      write_burst(2'd2, MEM_WORDS - 2, 3, 0);
      expect_resp(2'd2, SLVERR, 0);
      read_burst(2'd2, MEM_WORDS - 2, 3, 0);
      read_burst(2'd3, 0, 1, 0);
      end_test("test 4 burst past the end");

      for (n = 0; n < 8; n++) begin
         word = next_rand() % (MEM_WORDS - 8);
         len = next_rand() % 8;
         write_burst(2'(n), word, len, 0);
         expect_resp(2'(n), burst_resp(word, len), 1);
         read_burst(2'(n + 1), word, len, 1);
      end
      end_test("test 5 random bursts with stalls");

      // both ARs must get in while r_ready is low
      send_ar(2'd1, 32, 1);
      send_ar(2'd2, 16, 0);
      collect_read(2'd1, 32, 1, 0);
      collect_read(2'd2, 16, 0, 0);
      end_test("test 6 two reads in flight");

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

// ==== source/nasti_buf_chain.sv ====
// buffered NASTI memory path
`timescale 1ns/1ns

module nasti_buf_chain #(
   parameter int ID_WIDTH   = 2,
   parameter int ADDR_WIDTH = 12,
   parameter int DATA_WIDTH = 32,
   parameter int STAGES     = 2,
   parameter int DEPTH      = 2,
   parameter int BUF_REQ    = 1,
   parameter int BUF_RESP   = 1,
   parameter int MEM_WORDS  = 256
) (
   input  logic                           clk,
   input  logic                           rstn,
   input  logic [ID_WIDTH-1:0]            aw_id,
   input  logic [ADDR_WIDTH-1:0]          aw_addr,
   input  logic [nasti_pkg::nasti_len_w-1:0] aw_len,
   input  logic                           aw_valid,
   output logic                           aw_ready,
   input  logic [DATA_WIDTH-1:0]          w_data,
   input  logic [DATA_WIDTH/8-1:0]        w_strb,
   input  logic                           w_last,
   input  logic                           w_valid,
   output logic                           w_ready,
   output logic [ID_WIDTH-1:0]            b_id,
   output nasti_pkg::nasti_resp_e         b_resp,
   output logic                           b_valid,
   input  logic                           b_ready,
   input  logic [ID_WIDTH-1:0]            ar_id,
   input  logic [ADDR_WIDTH-1:0]          ar_addr,
   input  logic [nasti_pkg::nasti_len_w-1:0] ar_len,
   input  logic                           ar_valid,
   output logic                           ar_ready,
   output logic [ID_WIDTH-1:0]            r_id,
   output logic [DATA_WIDTH-1:0]          r_data,
   output nasti_pkg::nasti_resp_e         r_resp,
   output logic                           r_last,
   output logic                           r_valid,
   input  logic                           r_ready
);

   // ch[0] faces the ports, ch[STAGES] faces the memory
   nasti_channel #(
      .ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)
   ) ch [STAGES+1] ();

   assign ch[0].aw_id    = aw_id;
   assign ch[0].aw_addr  = aw_addr;
   assign ch[0].aw_len   = aw_len;
   assign ch[0].aw_valid = aw_valid;
   assign aw_ready       = ch[0].aw_ready;
   assign ch[0].w_data   = w_data;
   assign ch[0].w_strb   = w_strb;
   assign ch[0].w_last   = w_last;
   assign ch[0].w_valid  = w_valid;
   assign w_ready        = ch[0].w_ready;
   assign b_id           = ch[0].b_id;
   assign b_resp         = ch[0].b_resp;
   assign b_valid        = ch[0].b_valid;
   assign ch[0].b_ready  = b_ready;
   assign ch[0].ar_id    = ar_id;
   assign ch[0].ar_addr  = ar_addr;
   assign ch[0].ar_len   = ar_len;
   assign ch[0].ar_valid = ar_valid;
   assign ar_ready       = ch[0].ar_ready;
   assign r_id           = ch[0].r_id;
   assign r_data         = ch[0].r_data;
   assign r_resp         = ch[0].r_resp;
   assign r_last         = ch[0].r_last;
   assign r_valid        = ch[0].r_valid;
   assign ch[0].r_ready  = r_ready;

   for (genvar k = 0; k < STAGES; k++) begin : g_stage
      nasti_buf #(
         .DEPTH(DEPTH), .ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH),
         .DATA_WIDTH(DATA_WIDTH), .BUF_REQ(BUF_REQ), .BUF_RESP(BUF_RESP)
      ) u_buf (
         .clk    (clk),
         .rstn   (rstn),
         .master (ch[k]),
         .slave  (ch[k+1])
      );
   end

   nasti_mem #(
      .ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH),
      .DATA_WIDTH(DATA_WIDTH), .MEM_WORDS(MEM_WORDS)
   ) u_mem (
      .clk  (clk),
      .rstn (rstn),
      .bus  (ch[STAGES])
   );

endmodule

// ==== source/nasti_mem.sv ====
// NASTI memory slave
`timescale 1ns/1ns

module nasti_mem #(
   parameter int ID_WIDTH   = 2,
   parameter int ADDR_WIDTH = 12,
   parameter int DATA_WIDTH = 32,
   parameter int MEM_WORDS  = 256
) (
   input logic         clk,
   input logic         rstn,
   nasti_channel.slave bus
);
   import nasti_pkg::*;

   localparam int NB   = DATA_WIDTH / 8;
   localparam int OFF  = $clog2(NB);          // byte offset bits
   localparam int MW_W = $clog2(MEM_WORDS);

   logic [DATA_WIDTH-1:0]  mem [MEM_WORDS];

   mem_state_e             state;
   logic [ID_WIDTH-1:0]    id;
   logic [ADDR_WIDTH-1:0]  addr;   // word address of current beat
   logic [nasti_len_w-1:0] cnt;    // beats left after this one
   logic                   err;

   logic [ADDR_WIDTH-1:0]  req_addr;
   logic [nasti_len_w-1:0] req_len;
   logic [ADDR_WIDTH:0]    req_end;
   logic                   in_range;
   logic                   w_beat, r_beat;

   // AW takes priority in IDLE
   assign req_addr = (bus.aw_valid ? bus.aw_addr : bus.ar_addr) >> OFF;
   assign req_len  = bus.aw_valid ? bus.aw_len : bus.ar_len;
   assign req_end  = {1'b0, req_addr} + (ADDR_WIDTH + 1)'(req_len);   // last word of burst

   assign in_range = addr < ADDR_WIDTH'(MEM_WORDS);
   assign w_beat   = bus.w_valid && bus.w_ready;
   assign r_beat   = bus.r_valid && bus.r_ready;

   assign bus.aw_ready = state == IDLE;
   assign bus.ar_ready = state == IDLE && !bus.aw_valid;
   assign bus.w_ready  = state == WRITE_DATA;

   assign bus.b_valid  = state == WRITE_RESP;
   assign bus.b_id     = id;
   assign bus.b_resp   = err ? SLVERR : OKAY;

   assign bus.r_valid  = state == READ_DATA;
   assign bus.r_id     = id;
   assign bus.r_resp   = err ? SLVERR : OKAY;
   assign bus.r_last   = cnt == '0;
   assign bus.r_data   = in_range ? mem[addr[MW_W-1:0]] : '0;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE: begin
               if (bus.aw_valid)
                  state <= WRITE_DATA;
               else if (bus.ar_valid)
                  state <= READ_DATA;
            end
            WRITE_DATA: if (w_beat && bus.w_last) state <= WRITE_RESP;
            WRITE_RESP: if (bus.b_ready) state <= IDLE;
            READ_DATA:  if (r_beat && cnt == '0) state <= IDLE;
            default:    state <= IDLE;
         endcase
      end
   end

   // burst bookkeeping, address held while a beat is stalled
   always_ff @(posedge clk) begin
      if (state == IDLE && (bus.aw_valid || bus.ar_valid)) begin
         id   <= bus.aw_valid ? bus.aw_id : bus.ar_id;
         addr <= req_addr;
         cnt  <= req_len;
         err  <= req_end >= (ADDR_WIDTH + 1)'(MEM_WORDS);
      end else if (w_beat || r_beat) begin
         addr <= addr + 1'b1;
         cnt  <= cnt - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (w_beat && in_range) begin
         for (int i = 0; i < NB; i++)
            if (bus.w_strb[i])
               mem[addr[MW_W-1:0]][i*8 +: 8] <= bus.w_data[i*8 +: 8];
      end
   end

endmodule

// ==== source/nasti_buf.sv ====
// NASTI buffer stage
`timescale 1ns/1ns

module nasti_buf #(
   parameter int DEPTH      = 2,
   parameter int ID_WIDTH   = 2,
   parameter int ADDR_WIDTH = 12,
   parameter int DATA_WIDTH = 32,
   parameter int BUF_REQ    = 1,
   parameter int BUF_RESP   = 1
) (
   input logic          clk,
   input logic          rstn,
   nasti_channel.slave  master,
   nasti_channel.master slave
);
   import nasti_pkg::*;

   localparam int RESP_W = $bits(nasti_resp_e);
   localparam int AW_W   = ID_WIDTH + ADDR_WIDTH + nasti_len_w;   // AR shares this layout
   localparam int W_W    = DATA_WIDTH + DATA_WIDTH/8 + 1;
   localparam int B_W    = ID_WIDTH + RESP_W;
   localparam int R_W    = ID_WIDTH + DATA_WIDTH + RESP_W + 1;
   localparam int REQ_W  = (AW_W > W_W) ? AW_W : W_W;
   localparam int RSP_W  = (B_W > R_W) ? B_W : R_W;
   localparam int PW     = (REQ_W > RSP_W) ? REQ_W : RSP_W;

   // channel slots, requests first
   localparam int CH_AW = 0;
   localparam int CH_W  = 1;
   localparam int CH_AR = 2;
   localparam int CH_B  = 3;
   localparam int CH_R  = 4;
   localparam int NCH   = 5;

   logic [PW-1:0]  in_pl  [NCH];   // upstream side payload
   logic [PW-1:0]  out_pl [NCH];   // downstream side payload
   logic [NCH-1:0] in_valid, in_ready, out_valid, out_ready;

   // requests flow master -> slave
   assign in_pl[CH_AW]    = PW'({master.aw_id, master.aw_addr, master.aw_len});
   assign in_valid[CH_AW] = master.aw_valid;
   assign master.aw_ready = in_ready[CH_AW];
   assign {slave.aw_id, slave.aw_addr, slave.aw_len} = out_pl[CH_AW][AW_W-1:0];
   assign slave.aw_valid  = out_valid[CH_AW];
   assign out_ready[CH_AW] = slave.aw_ready;

   assign in_pl[CH_W]     = PW'({master.w_data, master.w_strb, master.w_last});
   assign in_valid[CH_W]  = master.w_valid;
   assign master.w_ready  = in_ready[CH_W];
   assign {slave.w_data, slave.w_strb, slave.w_last} = out_pl[CH_W][W_W-1:0];
   assign slave.w_valid   = out_valid[CH_W];
   assign out_ready[CH_W] = slave.w_ready;

   assign in_pl[CH_AR]    = PW'({master.ar_id, master.ar_addr, master.ar_len});
   assign in_valid[CH_AR] = master.ar_valid;
   assign master.ar_ready = in_ready[CH_AR];
   assign {slave.ar_id, slave.ar_addr, slave.ar_len} = out_pl[CH_AR][AW_W-1:0];
   assign slave.ar_valid  = out_valid[CH_AR];
   assign out_ready[CH_AR] = slave.ar_ready;

   // responses flow slave -> master
   assign in_pl[CH_B]     = PW'({slave.b_id, slave.b_resp});
   assign in_valid[CH_B]  = slave.b_valid;
   assign slave.b_ready   = in_ready[CH_B];
   assign master.b_id     = out_pl[CH_B][B_W-1:RESP_W];
   assign master.b_resp   = nasti_resp_e'(out_pl[CH_B][RESP_W-1:0]);
   assign master.b_valid  = out_valid[CH_B];
   assign out_ready[CH_B] = master.b_ready;

   assign in_pl[CH_R]     = PW'({slave.r_id, slave.r_data, slave.r_resp, slave.r_last});
   assign in_valid[CH_R]  = slave.r_valid;
   assign slave.r_ready   = in_ready[CH_R];
   assign {master.r_id, master.r_data} = out_pl[CH_R][R_W-1:RESP_W+1];
   assign master.r_resp   = nasti_resp_e'(out_pl[CH_R][RESP_W:1]);
   assign master.r_last   = out_pl[CH_R][0];
   assign master.r_valid  = out_valid[CH_R];
   assign out_ready[CH_R] = master.r_ready;

   for (genvar c = 0; c < NCH; c++) begin : g_ch
      localparam bit BUFFERED = (c <= CH_AR) ? (BUF_REQ != 0) : (BUF_RESP != 0);

      if (BUFFERED && DEPTH > 0) begin : g_fifo
         localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

         logic [PW-1:0]    q [DEPTH];
         logic [DEPTH-1:0] full;   // one flag per slot
         logic [PTR_W-1:0] wp, rp;

         always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
               wp   <= '0;
               rp   <= '0;
               full <= '0;
            end else begin
               if (in_valid[c] && in_ready[c]) begin
                  wp       <= (wp == PTR_W'(DEPTH - 1)) ? '0 : wp + 1'b1;
                  full[wp] <= 1'b1;
               end
               if (out_valid[c] && out_ready[c]) begin
                  rp       <= (rp == PTR_W'(DEPTH - 1)) ? '0 : rp + 1'b1;
                  full[rp] <= 1'b0;
               end
            end
         end

         always_ff @(posedge clk) begin
            if (in_valid[c] && in_ready[c])
               q[wp] <= in_pl[c];
         end

         assign in_ready[c]  = !full[wp];   // write slot free
         assign out_valid[c] = full[rp];
         assign out_pl[c]    = q[rp];
      end else begin : g_pass
         assign in_ready[c]  = out_ready[c];
         assign out_valid[c] = in_valid[c];
         assign out_pl[c]    = in_pl[c];
      end
   end

endmodule

// ==== source/nasti_channel.sv ====
// NASTI five channel bundle
`timescale 1ns/1ns

interface nasti_channel #(
   parameter int ID_WIDTH   = 2,
   parameter int ADDR_WIDTH = 12,
   parameter int DATA_WIDTH = 32
);
   import nasti_pkg::*;

   // AW
   logic [ID_WIDTH-1:0]     aw_id;
   logic [ADDR_WIDTH-1:0]   aw_addr;
   logic [nasti_len_w-1:0]  aw_len;
   logic                    aw_valid;
   logic                    aw_ready;

   // W
   logic [DATA_WIDTH-1:0]   w_data;
   logic [DATA_WIDTH/8-1:0] w_strb;
   logic                    w_last;
   logic                    w_valid;
   logic                    w_ready;

   // B
   logic [ID_WIDTH-1:0]     b_id;
   nasti_resp_e             b_resp;
   logic                    b_valid;
   logic                    b_ready;

   // AR
   logic [ID_WIDTH-1:0]     ar_id;
   logic [ADDR_WIDTH-1:0]   ar_addr;
   logic [nasti_len_w-1:0]  ar_len;
   logic                    ar_valid;
   logic                    ar_ready;

   // R
   logic [ID_WIDTH-1:0]     r_id;
   logic [DATA_WIDTH-1:0]   r_data;
   nasti_resp_e             r_resp;
   logic                    r_last;
   logic                    r_valid;
   logic                    r_ready;

   modport master (
      output aw_id, aw_addr, aw_len, aw_valid, w_data, w_strb, w_last, w_valid,
             b_ready, ar_id, ar_addr, ar_len, ar_valid, r_ready,
      input  aw_ready, w_ready, b_id, b_resp, b_valid, ar_ready,
             r_id, r_data, r_resp, r_last, r_valid
   );

   modport slave (
      input  aw_id, aw_addr, aw_len, aw_valid, w_data, w_strb, w_last, w_valid,
             b_ready, ar_id, ar_addr, ar_len, ar_valid, r_ready,
      output aw_ready, w_ready, b_id, b_resp, b_valid, ar_ready,
             r_id, r_data, r_resp, r_last, r_valid
   );

endinterface

// ==== source/nasti_pkg.sv ====
// NASTI shared types

package nasti_pkg;

   // burst length field, a burst carries len + 1 beats
   localparam int nasti_len_w = 8;

   typedef enum logic [1:0] {
      OKAY   = 2'd0,
      EXOKAY = 2'd1,   // not produced by this design
      SLVERR = 2'd2,
      DECERR = 2'd3    // not produced by this design
   } nasti_resp_e;

   // memory slave controller
   typedef enum logic [1:0] {
      IDLE,
      WRITE_DATA,
      WRITE_RESP,
      READ_DATA
   } mem_state_e;

endpackage
